// File: logic/alu_defines.svh
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Datapath widths
`define ALU_DATA_W      32
`define ALU_SHIFT_W     5
`define ALU_OPC_W       12

// Instruction format lives in the top byte of the control word
`define ALU_FMT_MSB     31
`define ALU_FMT_LSB     24
`define ALU_FMT_VOP1    8'd1
`define ALU_FMT_VOP2    8'd2
`define ALU_FMT_VOPC    8'd3
`define ALU_FMT_VOP3A   8'd4

// VOP3A source modifiers
`define ALU_ABS1_POS    12
`define ALU_ABS2_POS    13
`define ALU_NEG1_POS    14
`define ALU_NEG2_POS    15

`define ALU_MUL_CYCLES  3

// VOP1 and VOP2 opcodes
`define ALU_OPC_MOV     12'h001
`define ALU_OPC_ADD     12'h025
`define ALU_OPC_SUB     12'h026
`define ALU_OPC_AND     12'h01B
`define ALU_OPC_OR      12'h01C
`define ALU_OPC_SHL     12'h01A
`define ALU_OPC_SHR     12'h016
`define ALU_OPC_MAX     12'h014
`define ALU_OPC_MIN     12'h013
`define ALU_OPC_CNDMASK 12'h000

// Compare bases, low three bits select the predicate
`define ALU_OPC_CMP_S   12'h080
`define ALU_OPC_CMP_U   12'h0C0

// VOP3A opcodes
`define ALU_OPC_AND3    12'h11B
`define ALU_OPC_MAX3    12'h114
`define ALU_OPC_MIN3    12'h113
`define ALU_OPC_MUL_LO  12'h169
`define ALU_OPC_MUL_HI  12'h16A

`endif

// File: logic/alu_pkg.sv
`default_nettype none

`include "alu_defines.svh"

package alu_pkg;

  // Internal operations after format and opcode decode
  typedef enum logic [3:0] {
    op_mov,
    op_add,
    op_sub,
    op_and,
    op_or,
    op_shl,
    op_shr,
    op_max_u,
    op_min_u,
    op_cndmask,
    op_cmp_s,
    op_cmp_u,
    op_mul_lo,
    op_mul_hi,
    op_nop
  } alu_op_e;

  // One instruction as presented by the issue logic
  typedef struct packed {
    logic [`ALU_DATA_W-1:0] control;
    logic [`ALU_DATA_W-1:0] src1;
    logic [`ALU_DATA_W-1:0] src2;
    logic                   vcc;
    logic                   exec;
  } alu_req_t;

  typedef struct packed {
    alu_op_e                op;
    logic [2:0]             pred;      // Compare predicate, F LT EQ LE GT NE GE TRU
    logic [`ALU_DATA_W-1:0] a;         // Source 1 after modifiers
    logic [`ALU_DATA_W-1:0] b;         // Source 2 after modifiers
    logic                   vcc;
    logic                   active;    // Lane enabled by EXEC
  } alu_decoded_t;

  // Completed instruction
  typedef struct packed {
    logic [`ALU_DATA_W-1:0] data;
    logic                   vcc;
    logic                   write;     // VGPR write enable
  } alu_result_t;

endpackage

`default_nettype wire

// File: logic/alu_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module alu_decode (
  input  wire                   clk,
  input  wire                   rst,
  input  alu_pkg::alu_req_t     req,
  input  wire                   start,
  output logic                  ready,
  input  wire                   done,
  output alu_pkg::alu_decoded_t dec,
  output logic                  dec_valid
);

  logic                   busy;
  logic                   acc_q;       // Request taken last edge
  alu_pkg::alu_req_t      req_q;
  logic [7:0]             fmt;
  logic [`ALU_OPC_W-1:0]  opc;
  logic                   is_vop3a;
  logic                   cmp_s_hit;
  logic                   cmp_u_hit;
  alu_pkg::alu_op_e       op_d;

  // Abs is applied before negate, both as two's complement
  function automatic logic [`ALU_DATA_W-1:0] apply_mod(input logic [`ALU_DATA_W-1:0] x,
                                                       input logic abs_en,
                                                       input logic neg_en);
    logic [`ALU_DATA_W-1:0] m;
    m = (abs_en && x[`ALU_DATA_W-1]) ? -x : x;
    return neg_en ? -m : m;
  endfunction

  assign ready = ~busy | done;         // Reopens together with done

  assign fmt       = req_q.control[`ALU_FMT_MSB:`ALU_FMT_LSB];
  assign opc       = req_q.control[`ALU_OPC_W-1:0];
  assign is_vop3a  = (fmt == `ALU_FMT_VOP3A);
  assign cmp_s_hit = ({opc[`ALU_OPC_W-1:3], 3'b000} == `ALU_OPC_CMP_S);
  assign cmp_u_hit = ({opc[`ALU_OPC_W-1:3], 3'b000} == `ALU_OPC_CMP_U);

  always_comb
  begin
    op_d = alu_pkg::op_nop;            // Unknown combinations fall here
    case (fmt)
      `ALU_FMT_VOP1:
      begin
        if (opc == `ALU_OPC_MOV)
          op_d = alu_pkg::op_mov;
      end
      `ALU_FMT_VOP2:
      begin
        case (opc)
          `ALU_OPC_ADD:     op_d = alu_pkg::op_add;
          `ALU_OPC_SUB:     op_d = alu_pkg::op_sub;
          `ALU_OPC_AND:     op_d = alu_pkg::op_and;
          `ALU_OPC_OR:      op_d = alu_pkg::op_or;
          `ALU_OPC_SHL:     op_d = alu_pkg::op_shl;
          `ALU_OPC_SHR:     op_d = alu_pkg::op_shr;
          `ALU_OPC_MAX:     op_d = alu_pkg::op_max_u;
          `ALU_OPC_MIN:     op_d = alu_pkg::op_min_u;
          `ALU_OPC_CNDMASK: op_d = alu_pkg::op_cndmask;
          default:          op_d = alu_pkg::op_nop;
        endcase
      end
      `ALU_FMT_VOPC, `ALU_FMT_VOP3A:
      begin
        if (cmp_s_hit)
          op_d = alu_pkg::op_cmp_s;
        else if (cmp_u_hit)
          op_d = alu_pkg::op_cmp_u;
        else if (is_vop3a)
        begin
          case (opc)
            `ALU_OPC_AND3:   op_d = alu_pkg::op_and;
            `ALU_OPC_MAX3:   op_d = alu_pkg::op_max_u;
            `ALU_OPC_MIN3:   op_d = alu_pkg::op_min_u;
            `ALU_OPC_MUL_LO: op_d = alu_pkg::op_mul_lo;
            `ALU_OPC_MUL_HI: op_d = alu_pkg::op_mul_hi;
            default:         op_d = alu_pkg::op_nop;
          endcase
        end
      end
      default: op_d = alu_pkg::op_nop;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      busy      <= 1'b0;
      acc_q     <= 1'b0;
      dec_valid <= 1'b0;
    end
    else
    begin
      acc_q     <= start & ready;
      dec_valid <= acc_q;
      if (start && ready)
        busy <= 1'b1;
      else if (done)
        busy <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (start && ready)
      req_q <= req;
    if (acc_q)
    begin
      dec.op     <= op_d;
      dec.pred   <= opc[2:0];
      dec.a      <= apply_mod(req_q.src1, is_vop3a & req_q.control[`ALU_ABS1_POS],
                              is_vop3a & req_q.control[`ALU_NEG1_POS]);
      dec.b      <= apply_mod(req_q.src2, is_vop3a & req_q.control[`ALU_ABS2_POS],
                              is_vop3a & req_q.control[`ALU_NEG2_POS]);
      dec.vcc    <= req_q.vcc;
      dec.active <= req_q.exec;        // EXEC low completes without a write
    end
  end

endmodule

`default_nettype wire

// File: logic/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module alu_execute (
  input  wire                          clk,
  input  wire                          rst,
  input  alu_pkg::alu_decoded_t        dec,
  input  wire                          dec_valid,
  output logic                         mul_start,
  output logic [`ALU_DATA_W-1:0]       mul_a,
  output logic [`ALU_DATA_W-1:0]       mul_b,
  input  wire  [2*`ALU_DATA_W-1:0]     mul_product,
  input  wire                          mul_done,
  output alu_pkg::alu_result_t         res,
  output logic                         res_valid
);

  logic [`ALU_DATA_W:0]   sum;         // Bit 32 is the carry
  logic [`ALU_DATA_W:0]   diff;        // Bit 32 is the borrow
  logic [`ALU_SHIFT_W-1:0] shamt;
  logic                   lt;
  logic                   eq;
  logic                   gt;
  logic                   cmp_vcc;
  logic                   is_mul;
  logic                   mul_hi_q;    // Which product half to return
  logic                   mul_vcc_q;

  assign sum   = {1'b0, dec.a} + {1'b0, dec.b};
  assign diff  = {1'b0, dec.a} - {1'b0, dec.b};
  assign shamt = dec.a[`ALU_SHIFT_W-1:0];

  assign eq = (dec.a == dec.b);
  assign lt = (dec.op == alu_pkg::op_cmp_s) ? ($signed(dec.a) < $signed(dec.b))
                                            : (dec.a < dec.b);
  assign gt = ~lt & ~eq;
  // Predicate bits line up with LT, EQ and GT
  assign cmp_vcc = (dec.pred[0] & lt) | (dec.pred[1] & eq) | (dec.pred[2] & gt);

  assign is_mul    = dec.active &&
                     (dec.op == alu_pkg::op_mul_lo || dec.op == alu_pkg::op_mul_hi);
  assign mul_start = dec_valid & is_mul;
  assign mul_a     = dec.a;
  assign mul_b     = dec.b;
  assign res_valid = (dec_valid & ~is_mul) | mul_done;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      mul_hi_q  <= 1'b0;
      mul_vcc_q <= 1'b0;
    end
    else if (mul_start)
    begin
      mul_hi_q  <= (dec.op == alu_pkg::op_mul_hi);
      mul_vcc_q <= dec.vcc;
    end
  end

  always_comb
  begin
    res.data  = '0;
    res.vcc   = dec.vcc;                // Pass-through unless the op sets it
    res.write = 1'b0;
    if (mul_done)
    begin
      res.data  = mul_hi_q ? mul_product[2*`ALU_DATA_W-1:`ALU_DATA_W]
                           : mul_product[`ALU_DATA_W-1:0];
      res.vcc   = mul_vcc_q;
      res.write = 1'b1;
    end
    else if (dec.active)
    begin
      res.write = 1'b1;
      case (dec.op)
        alu_pkg::op_mov:     res.data = dec.a;
        alu_pkg::op_add:
        begin
          res.data = sum[`ALU_DATA_W-1:0];
          res.vcc  = sum[`ALU_DATA_W];
        end
        alu_pkg::op_sub:
        begin
          res.data = diff[`ALU_DATA_W-1:0];
          res.vcc  = diff[`ALU_DATA_W];
        end
        alu_pkg::op_and:     res.data = dec.a & dec.b;
        alu_pkg::op_or:      res.data = dec.a | dec.b;
        alu_pkg::op_shl:     res.data = dec.b << shamt;   // Reversed operands
        alu_pkg::op_shr:     res.data = dec.b >> shamt;
        alu_pkg::op_max_u:   res.data = (dec.a >= dec.b) ? dec.a : dec.b;
        alu_pkg::op_min_u:   res.data = (dec.a <= dec.b) ? dec.a : dec.b;
        alu_pkg::op_cndmask: res.data = dec.vcc ? dec.b : dec.a;
        alu_pkg::op_cmp_s, alu_pkg::op_cmp_u:
        begin
          res.vcc   = cmp_vcc;
          res.write = 1'b0;             // Compares only update VCC
        end
        default:             res.write = 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/alu_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module alu_multiplier (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      start,
  input  wire  [`ALU_DATA_W-1:0]   a,
  input  wire  [`ALU_DATA_W-1:0]   b,
  output logic [2*`ALU_DATA_W-1:0] product,
  output logic                     done
);

  localparam int CNT_W = $clog2(`ALU_MUL_CYCLES + 1);

  logic [CNT_W-1:0]       cnt;
  logic                   busy;
  logic                   last;        // Final counting cycle
  logic [`ALU_DATA_W-1:0] a_q;
  logic [`ALU_DATA_W-1:0] b_q;

  assign last = busy && (cnt == CNT_W'(`ALU_MUL_CYCLES - 1));

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      cnt  <= '0;
      busy <= 1'b0;
      done <= 1'b0;
    end
    else
    begin
      done <= last;
      if (start)
      begin
        busy <= 1'b1;
        cnt  <= CNT_W'(1);
      end
      else if (last)
        busy <= 1'b0;
      else if (busy)
        cnt <= cnt + CNT_W'(1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      a_q <= a;
      b_q <= b;
    end
    if (last)
      product <= {{`ALU_DATA_W{1'b0}}, a_q} * {{`ALU_DATA_W{1'b0}}, b_q};
  end

endmodule

`default_nettype wire

// File: logic/alu_result.sv
`timescale 1ns/1ps
`default_nettype none

module alu_result (
  input  wire                  clk,
  input  wire                  rst,
  input  alu_pkg::alu_result_t res_in,
  input  wire                  res_valid,
  output alu_pkg::alu_result_t result,
  output logic                 done
);

  // Result stays put between completions
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      result <= '0;
      done   <= 1'b0;
    end
    else
    begin
      done <= res_valid;               // One-cycle pulse per instruction
      if (res_valid)
        result <= res_in;
    end
  end

endmodule

`default_nettype wire

// File: logic/alu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module alu_top (
  input  wire                  clk,
  input  wire                  rst,
  input  alu_pkg::alu_req_t    req,
  input  wire                  start,
  output logic                 ready,
  output alu_pkg::alu_result_t result,
  output logic                 done
);

  alu_pkg::alu_decoded_t      dec;
  logic                       dec_valid;
  logic                       mul_start;
  logic [`ALU_DATA_W-1:0]     mul_a;
  logic [`ALU_DATA_W-1:0]     mul_b;
  logic [2*`ALU_DATA_W-1:0]   mul_product;
  logic                       mul_done;
  alu_pkg::alu_result_t       exec_res;
  logic                       exec_valid;

  alu_decode u_decode (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .start     (start),
    .ready     (ready),
    .done      (done),
    .dec       (dec),
    .dec_valid (dec_valid)
  );

  alu_execute u_execute (
    .clk         (clk),
    .rst         (rst),
    .dec         (dec),
    .dec_valid   (dec_valid),
    .mul_start   (mul_start),
    .mul_a       (mul_a),
    .mul_b       (mul_b),
    .mul_product (mul_product),
    .mul_done    (mul_done),
    .res         (exec_res),
    .res_valid   (exec_valid)
  );

  alu_multiplier u_multiplier (
    .clk     (clk),
    .rst     (rst),
    .start   (mul_start),
    .a       (mul_a),
    .b       (mul_b),
    .product (mul_product),
    .done    (mul_done)
  );

  alu_result u_result (
    .clk       (clk),
    .rst       (rst),
    .res_in    (exec_res),
    .res_valid (exec_valid),
    .result    (result),
    .done      (done)
  );

endmodule

`default_nettype wire

// File: testbench/alu_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module alu_checker (
  input wire clk,
  input wire rst,
  input wire start,
  input wire ready,
  input wire done,
  input wire write
);

  logic waiting;         // Instruction in flight
  int   wait_cnt;
  int   fail_cnt = 0;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      waiting  <= 1'b0;
      wait_cnt <= 0;
    end
    else if (start && ready)
    begin
      waiting  <= 1'b1;
      wait_cnt <= 0;
    end
    else if (done)
      waiting <= 1'b0;
    else if (waiting)
      wait_cnt <= wait_cnt + 1;
  end

  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else
    begin
      fail_cnt++;
      $error("done stayed high for more than one cycle");
    end

  // No second request can be taken before done
  a_no_busy_accept: assert property (@(posedge clk) disable iff (rst)
    (waiting && !done) |-> !ready)
    else
    begin
      fail_cnt++;
      $error("ready high while an instruction was in flight");
    end

  // Multiplies are the longest path
  a_latency: assert property (@(posedge clk) disable iff (rst)
    waiting |-> (wait_cnt <= `ALU_MUL_CYCLES + 2))
    else
    begin
      fail_cnt++;
      $error("done arrived later than the multiply latency");
    end

  a_reset_write: assert property (@(posedge clk) rst |=> !write)
    else
    begin
      fail_cnt++;
      $error("result write enable high right after reset");
    end

endmodule

bind alu_top alu_checker u_checker (
  .clk      (clk),
  .rst      (rst),
  .start    (start),
  .ready    (ready),
  .done     (done),
  .write    (result.write)
);

`default_nettype wire

// File: testbench/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module alu_tb;

  typedef struct packed {
    alu_pkg::alu_req_t    req;
    alu_pkg::alu_result_t exp;
  } vec_t;

  localparam int num_random     = 40;
  localparam int cycles_per_vec = 20;

  logic                 clk;
  logic                 rst;
  logic                 start;
  logic                 ready;
  logic                 done;
  alu_pkg::alu_req_t    req;
  alu_pkg::alu_result_t result;

  vec_t   vecs[$];
  string  vec_names[$];
  integer seed = 7442;
  int     cycles = 0;
  int     cycle_limit;

  alu_top u_dut (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .start  (start),
    .ready  (ready),
    .result (result),
    .done   (done)
  );

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit)
    begin
      $display("Timeout after %0d cycles, the DUT never completed the tests", cycles);
      $display("Checks failed");
      $fatal(1, "Simulation timeout");
    end
  end

  function automatic logic [31:0] vop1(input logic [11:0] opc);
    return {`ALU_FMT_VOP1, 12'h000, opc};
  endfunction

  function automatic logic [31:0] vop2(input logic [11:0] opc);
    return {`ALU_FMT_VOP2, 12'h000, opc};
  endfunction

  function automatic logic [31:0] vopc(input logic [11:0] opc);
    return {`ALU_FMT_VOPC, 12'h000, opc};
  endfunction

  // Modifiers are {neg2, neg1, abs2, abs1}
  function automatic logic [31:0] vop3a(input logic [11:0] opc, input logic [3:0] mods);
    return {`ALU_FMT_VOP3A, 8'h00, mods, opc};
  endfunction

  function automatic int expected_latency(input alu_pkg::alu_req_t r);
    logic is_mul;
    is_mul = (r.control[31:24] == `ALU_FMT_VOP3A) &&
             (r.control[11:0] == `ALU_OPC_MUL_LO || r.control[11:0] == `ALU_OPC_MUL_HI);
    return (is_mul && r.exec) ? 2 + `ALU_MUL_CYCLES : 2;
  endfunction

  // Reference for add, sub and compares
  function automatic alu_pkg::alu_result_t model_result(input alu_pkg::alu_req_t r);
    alu_pkg::alu_result_t e;
    logic [11:0]          opc;
    logic [63:0]          wide;
    logic                 lt;
    logic                 eq;
    opc     = r.control[11:0];
    e.data  = '0;
    e.vcc   = r.vcc;
    e.write = 1'b0;
    if ((opc & 12'hFF8) == `ALU_OPC_CMP_U)
      lt = r.src1 < r.src2;
    else
      lt = $signed(r.src1) < $signed(r.src2);
    eq = (r.src1 == r.src2);
    if (r.exec)
    begin
      if (opc == `ALU_OPC_ADD)
      begin
        wide    = 64'(r.src1) + 64'(r.src2);
        e.data  = wide[31:0];
        e.vcc   = wide[32];              // Carry out
        e.write = 1'b1;
      end
      else if (opc == `ALU_OPC_SUB)
      begin
        e.data  = r.src1 - r.src2;
        e.vcc   = (r.src1 < r.src2);     // Borrow
        e.write = 1'b1;
      end
      else
      begin
        case (opc[2:0])
          3'd0:    e.vcc = 1'b0;
          3'd1:    e.vcc = lt;
          3'd2:    e.vcc = eq;
          3'd3:    e.vcc = lt | eq;
          3'd4:    e.vcc = !lt && !eq;
          3'd5:    e.vcc = !eq;
          3'd6:    e.vcc = !lt;
          default: e.vcc = 1'b1;
        endcase
      end
    end
    return e;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      $display("Checks failed");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  task automatic add_vec(input string name, input logic [31:0] ctl, input logic [31:0] s1,
                         input logic [31:0] s2, input int vin, input int ex,
                         input logic [31:0] d, input int vout, input int wr);
    vec_t v;
    v.req.control = ctl;
    v.req.src1    = s1;
    v.req.src2    = s2;
    v.req.vcc     = (vin != 0);
    v.req.exec    = (ex != 0);
    v.exp.data    = d;
    v.exp.vcc     = (vout != 0);
    v.exp.write   = (wr != 0);
    vecs.push_back(v);
    vec_names.push_back(name);
  endtask

  task automatic build_table();
    logic [7:0] neg_vs_one;   // -1 against 1, signed
    logic [7:0] big_vs_one;   // 0xFFFFFFFF against 1, unsigned
    logic [7:0] same;         // Equal operands
    neg_vs_one = 8'hAA;
    big_vs_one = 8'hF0;
    same       = 8'hCC;
    // name, control, src1, src2, vcc in, exec, data, vcc out, write
    add_vec("add_basic", vop2(`ALU_OPC_ADD), 32'h5, 32'h7, 0, 1, 32'hC, 0, 1);
    add_vec("add_carry", vop2(`ALU_OPC_ADD), 32'hFFFF_FFFF, 32'h1, 0, 1, 32'h0, 1, 1);
    add_vec("add_vcc_in", vop2(`ALU_OPC_ADD), 32'h3, 32'h4, 1, 1, 32'h7, 0, 1);
    add_vec("sub_basic", vop2(`ALU_OPC_SUB), 32'hA, 32'h3, 0, 1, 32'h7, 0, 1);
    add_vec("sub_borrow", vop2(`ALU_OPC_SUB), 32'h3, 32'hA, 0, 1, 32'hFFFF_FFF9, 1, 1);
    add_vec("and", vop2(`ALU_OPC_AND), 32'hF0F0_F0F0, 32'h3C3C_3C3C, 1, 1, 32'h3030_3030, 1, 1);
    add_vec("or", vop2(`ALU_OPC_OR), 32'hF0F0_F0F0, 32'h0F00_0F00, 0, 1, 32'hFFF0_FFF0, 0, 1);
    add_vec("shl", vop2(`ALU_OPC_SHL), 32'h4, 32'hF1, 1, 1, 32'hF10, 1, 1);
    add_vec("shl_amt_low5", vop2(`ALU_OPC_SHL), 32'h23, 32'h8000_0001, 0, 1, 32'h8, 0, 1);
    add_vec("shr", vop2(`ALU_OPC_SHR), 32'h8, 32'h8000_0000, 1, 1, 32'h0080_0000, 1, 1);
    add_vec("max_u", vop2(`ALU_OPC_MAX), 32'hFFFF_FFFF, 32'h1, 0, 1, 32'hFFFF_FFFF, 0, 1);
    add_vec("min_u", vop2(`ALU_OPC_MIN), 32'hFFFF_FFFF, 32'h1, 0, 1, 32'h1, 0, 1);
    add_vec("mov", vop1(`ALU_OPC_MOV), 32'hDEAD_BEEF, 32'h1234_5678, 1, 1, 32'hDEAD_BEEF, 1, 1);
    add_vec("cndmask_vcc0", vop2(`ALU_OPC_CNDMASK), 32'h11, 32'h22, 0, 1, 32'h11, 0, 1);
    add_vec("cndmask_vcc1", vop2(`ALU_OPC_CNDMASK), 32'h11, 32'h22, 1, 1, 32'h22, 1, 1);
    add_vec("vop2_mod_bits", vop2(`ALU_OPC_MAX) | 32'h4000, 32'h5, 32'h7, 0, 1, 32'h7, 0, 1);
    for (int p = 0; p < 8; p++)
    begin
      add_vec($sformatf("vopc_s_p%0d", p), vopc(`ALU_OPC_CMP_S | 12'(p)), 32'hFFFF_FFFF,
              32'h1, int'(!neg_vs_one[p]), 1, 32'h0, int'(neg_vs_one[p]), 0);
      add_vec($sformatf("vopc_u_p%0d", p), vopc(`ALU_OPC_CMP_U | 12'(p)), 32'hFFFF_FFFF,
              32'h1, int'(!big_vs_one[p]), 1, 32'h0, int'(big_vs_one[p]), 0);
      add_vec($sformatf("vop3_s_eq_p%0d", p), vop3a(`ALU_OPC_CMP_S | 12'(p), 4'h0), 32'h5,
              32'h5, int'(!same[p]), 1, 32'h0, int'(same[p]), 0);
      add_vec($sformatf("vop3_u_p%0d", p), vop3a(`ALU_OPC_CMP_U | 12'(p), 4'h0), 32'h2,
              32'hFFFF_0000, int'(!neg_vs_one[p]), 1, 32'h0, int'(neg_vs_one[p]), 0);
    end
    add_vec("max3_neg1", vop3a(`ALU_OPC_MAX3, 4'b0100), 32'h5, 32'h7, 0, 1, 32'hFFFF_FFFB, 0, 1);
    add_vec("min3_abs1", vop3a(`ALU_OPC_MIN3, 4'b0001), 32'hFFFF_FFF6, 32'h14, 0, 1, 32'hA, 0, 1);
    add_vec("and3_neg2", vop3a(`ALU_OPC_AND3, 4'b1000), 32'h1234, 32'h1, 1, 1, 32'h1234, 1, 1);
    add_vec("and3_abs_neg2", vop3a(`ALU_OPC_AND3, 4'b1010), 32'hFFFF_FFFF, 32'hFFFF_FFFB,
            0, 1, 32'hFFFF_FFFB, 0, 1);
    add_vec("cmp3_lt_abs1", vop3a(`ALU_OPC_CMP_S | 12'd1, 4'b0001), 32'hFFFF_FFFD, 32'h2,
            1, 1, 32'h0, 0, 0);
    add_vec("mul_lo_max", vop3a(`ALU_OPC_MUL_LO, 4'h0), 32'hFFFF_FFFF, 32'hFFFF_FFFF,
            1, 1, 32'h1, 1, 1);
    add_vec("mul_hi_max", vop3a(`ALU_OPC_MUL_HI, 4'h0), 32'hFFFF_FFFF, 32'hFFFF_FFFF,
            0, 1, 32'hFFFF_FFFE, 0, 1);
    add_vec("mul_hi_2p32", vop3a(`ALU_OPC_MUL_HI, 4'h0), 32'h1_0000, 32'h1_0000, 0, 1, 32'h1, 0, 1);
    add_vec("mul_lo_2p32", vop3a(`ALU_OPC_MUL_LO, 4'h0), 32'h1_0000, 32'h1_0000, 0, 1, 32'h0, 0, 1);
    add_vec("mul_lo_small", vop3a(`ALU_OPC_MUL_LO, 4'h0), 32'h1_2345, 32'h100, 1, 1,
            32'h0123_4500, 1, 1);
    add_vec("mul_lo_neg1", vop3a(`ALU_OPC_MUL_LO, 4'b0100), 32'h1, 32'h2, 0, 1,
            32'hFFFF_FFFE, 0, 1);
    add_vec("mul_hi_neg1", vop3a(`ALU_OPC_MUL_HI, 4'b0100), 32'h1, 32'h2, 0, 1, 32'h1, 0, 1);
    add_vec("mul_exec_off", vop3a(`ALU_OPC_MUL_LO, 4'h0), 32'h3, 32'h3, 1, 0, 32'h0, 1, 0);
    add_vec("add_exec_off", vop2(`ALU_OPC_ADD), 32'h1, 32'h1, 1, 0, 32'h0, 1, 0);
    add_vec("cmp_exec_off", vopc(`ALU_OPC_CMP_S | 12'd7), 32'h1, 32'h1, 0, 0, 32'h0, 0, 0);
    add_vec("unknown_vop2", vop2(12'h0FF), 32'h1, 32'h2, 1, 1, 32'h0, 1, 0);
    add_vec("unknown_fmt", 32'h0700_0025, 32'h1, 32'h2, 0, 1, 32'h0, 0, 0);
    add_vec("vopc_not_cmp", vopc(`ALU_OPC_AND3), 32'h1, 32'h1, 1, 1, 32'h0, 1, 0);
    add_vec("vop1_not_mov", vop1(`ALU_OPC_ADD), 32'h1, 32'h1, 0, 1, 32'h0, 0, 0);
  endtask

  task automatic add_random(input int count);
    alu_pkg::alu_req_t r;
    vec_t              v;
    logic [31:0]       pick;
    for (int i = 0; i < count; i++)
    begin
      pick = $random(seed);
      case (pick[1:0])
        2'd0:    r.control = vop2(`ALU_OPC_ADD);
        2'd1:    r.control = vop2(`ALU_OPC_SUB);
        2'd2:    r.control = vopc(`ALU_OPC_CMP_S | 12'(pick[4:2]));
        default: r.control = vopc(`ALU_OPC_CMP_U | 12'(pick[4:2]));
      endcase
      r.src1 = $random(seed);
      r.src2 = (pick[7:5] == 3'd0) ? r.src1 : $random(seed);   // Some equal pairs
      r.vcc  = pick[8];
      r.exec = (pick[11:9] != 3'd0);                          // Mostly enabled
      v.req  = r;
      v.exp  = model_result(r);
      vecs.push_back(v);
      vec_names.push_back($sformatf("rand_%0d", i));
    end
  endtask

  task automatic run_vec(input string name, input vec_t v);
    int lat;
    @(negedge clk);
    while (!ready)
      @(negedge clk);
    @(posedge clk);
    req   <= v.req;
    start <= 1'b1;
    @(posedge clk);                      // Accepting edge
    start <= 1'b0;
    lat = 0;
    @(negedge clk);
    while (!done)
    begin
      @(negedge clk);
      lat++;
    end
    check_value({name, " data"}, v.exp.data, result.data);
    check_value({name, " vcc"}, 32'(v.exp.vcc), 32'(result.vcc));
    check_value({name, " write"}, 32'(v.exp.write), 32'(result.write));
    check_value({name, " latency"}, 32'(expected_latency(v.req)), 32'(lat));
  endtask

  initial
  begin
    clk   = 1'b0;
    rst   = 1'b1;
    start = 1'b0;
    req   = '0;
    build_table();
    add_random(num_random);
    cycle_limit = cycles_per_vec * vecs.size() + 20;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    foreach (vecs[i])
      run_vec(vec_names[i], vecs[i]);
    if (u_dut.u_checker.fail_cnt == 0)
    begin
      $display("All checks passed");
      $finish;
    end
    else
    begin
      $display("Checks failed");
      $fatal(1, "%0d assertion failures", u_dut.u_checker.fail_cnt);
    end
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+logic
logic/alu_pkg.sv
logic/alu_decode.sv
logic/alu_execute.sv
logic/alu_multiplier.sv
logic/alu_result.sv
logic/alu_top.sv
testbench/alu_checker.sv
testbench/alu_tb.sv

// File: Makefile
TOP = alu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)_sim
	out=$$(./obj_dir/$(TOP)_sim 2>&1); echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
